// File: sources.f
+incdir+hw
hw/rv_pkg.sv
hw/rv_ctrl_fsm.sv
hw/rv_pc_counter.sv
hw/rv_regfile.sv
hw/rv_decoder.sv
hw/rv_alu.sv
hw/rv_core_top.sv
sim/rv_core_tb.sv

// File: run_sim.sh
#!/bin/sh
# build and run the core testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module rv_core_tb -f sources.f -o rv_core_sim

if ! ./obj_dir/rv_core_sim > sim.log 2>&1; then
	cat sim.log
	echo "simulation exited with an error"
	exit 1
fi
cat sim.log

if grep -q "Test failed" sim.log; then
	exit 1
fi
exit 0

// File: sim/rv_core_tb.sv
`timescale 1ns/1ps
`include "rv_consts.svh"

module rv_core_tb;

	// fetched words per program, ebreak and the load included
	localparam int A_LEN       = 23;
	localparam int B_LEN       = 3;
	localparam int CYCLE_LIMIT = 3 * (A_LEN + B_LEN) + 50;

	logic        clk;
	logic        rst;
	logic [31:0] imem_data;
	logic [31:0] imem_addr;
	logic [31:0] pc;
	logic        wb_en;
	logic [4:0]  wb_reg;
	logic [31:0] wb_data;
	logic [31:0] instret;
	logic        halt;
	logic        invalid;

	// program image and expected tables, indexed by instret
	logic [31:0] imem [64];
	logic        exp_wen [32];
	logic [4:0]  exp_rd [32];
	logic [31:0] exp_val [32];
	logic [31:0] exp_pc [32];
	logic [31:0] exp_count;
	logic        expect_invalid;
	logic [31:0] next_pc;
	logic [4:0]  n_insn;
	integer      seed;
	string       test_name;
	int          errors      = 0;
	int          writes_seen = 0;
	int          cycles      = 0;

	// instruction memory answers in the same cycle
	assign imem_data = imem[imem_addr[7:2]];

	rv_core_top dut_i (
		.clk         (clk),
		.rst         (rst),
		.imem_data_i (imem_data),
		.imem_addr_o (imem_addr),
		.pc_o        (pc),
		.wb_en_o     (wb_en),
		.wb_reg_o    (wb_reg),
		.wb_data_o   (wb_data),
		.instret_o   (instret),
		.halt_o      (halt),
		.invalid_o   (invalid)
	);

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	// instruction encoders, field order from the ISA
	function automatic logic [31:0] r_type(input logic [6:0] f7, input logic [4:0] rs2,
		input logic [4:0] rs1, input logic [2:0] f3, input logic [4:0] rd);
		return {f7, rs2, rs1, f3, rd, `RV_OP_REG};
	endfunction

	function automatic logic [31:0] i_type(input logic [11:0] imm, input logic [4:0] rs1,
		input logic [2:0] f3, input logic [4:0] rd, input logic [6:0] op);
		return {imm, rs1, f3, rd, op};
	endfunction

	function automatic logic [31:0] u_type(input logic [19:0] imm, input logic [4:0] rd,
		input logic [6:0] op);
		return {imm, rd, op};
	endfunction

	// jal offset, bit 0 implied
	function automatic logic [31:0] j_type(input logic [20:0] off, input logic [4:0] rd);
		return {off[20], off[10:1], off[11], off[19:12], rd, `RV_OP_JAL};
	endfunction

	function automatic logic [31:0] b_type(input logic [12:0] off, input logic [4:0] rs2,
		input logic [4:0] rs1, input logic [2:0] f3);
		return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], `RV_OP_BRANCH};
	endfunction

	function automatic logic [31:0] sext12(input logic [11:0] imm);
		return {{20{imm[11]}}, imm};
	endfunction

	task automatic clear_image;
		// unused words decode as opcode 0, never legal
		for (int i = 0; i < 64; i++) begin
			imem[i[5:0]] = {i[24:0], 7'b0000000};
		end
		for (int i = 0; i < 32; i++) begin
			exp_wen[i[4:0]] = 1'b0;
			exp_rd[i[4:0]]  = 5'd0;
			exp_val[i[4:0]] = 32'd0;
			exp_pc[i[4:0]]  = 32'd0;
		end
		next_pc = `RV_RESET_PC;
		n_insn  = 5'd0;
	endtask

	// word that retires, with its fetch pc and its write
	task automatic expect_insn(input logic [31:0] word, input logic wen, input logic [4:0] rd,
		input logic [31:0] val);
		imem[next_pc[7:2]] = word;
		exp_pc[n_insn]     = next_pc;
		exp_wen[n_insn]    = wen;
		exp_rd[n_insn]     = rd;
		exp_val[n_insn]    = val;
		n_insn             = n_insn + 5'd1;
		next_pc            = next_pc + 32'd4;
	endtask

	// jumped over, never fetched
	task automatic pad_insn(input logic [31:0] word);
		imem[next_pc[7:2]] = word;
		next_pc            = next_pc + 32'd4;
	endtask

	// last fetch, stops the core
	task automatic stop_insn(input logic [31:0] word);
		imem[next_pc[7:2]] = word;
		exp_pc[n_insn]     = next_pc;
		exp_count          = {27'd0, n_insn};
	endtask

	task automatic assemble_main;
		logic [31:0] r;
		logic [11:0] imm1;
		logic [11:0] imm2;
		logic [31:0] x1;
		logic [31:0] x2;
		logic [31:0] land;
		r    = $random(seed);
		imm1 = r[11:0];
		r    = $random(seed);
		imm2 = r[11:0];
		x1   = sext12(imm1);
		x2   = sext12(imm2);
		clear_image();
		expect_insn(i_type(imm1, 5'd0, `RV_F3_ADD_SUB, 5'd1, `RV_OP_IMM), 1'b1, 5'd1, x1);
		expect_insn(i_type(imm2, 5'd0, `RV_F3_ADD_SUB, 5'd2, `RV_OP_IMM), 1'b1, 5'd2, x2);
		expect_insn(r_type(`RV_F7_BASE, 5'd2, 5'd1, `RV_F3_ADD_SUB, 5'd3), 1'b1, 5'd3, x1 + x2);
		expect_insn(r_type(`RV_F7_ALT, 5'd2, 5'd1, `RV_F3_ADD_SUB, 5'd4), 1'b1, 5'd4, x1 - x2);
		expect_insn(r_type(`RV_F7_BASE, 5'd2, 5'd1, `RV_F3_XOR, 5'd6), 1'b1, 5'd6, x1 ^ x2);
		expect_insn(r_type(`RV_F7_BASE, 5'd2, 5'd1, `RV_F3_OR, 5'd7), 1'b1, 5'd7, x1 | x2);
		expect_insn(r_type(`RV_F7_BASE, 5'd2, 5'd1, `RV_F3_AND, 5'd8), 1'b1, 5'd8, x1 & x2);
		expect_insn(r_type(`RV_F7_BASE, 5'd2, 5'd1, `RV_F3_SLT, 5'd9), 1'b1, 5'd9,
			{31'd0, $signed(x1) < $signed(x2)});
		expect_insn(r_type(`RV_F7_BASE, 5'd2, 5'd1, `RV_F3_SLTU, 5'd10), 1'b1, 5'd10,
			{31'd0, x1 < x2});
		// shift amount from x2[4:0]
		expect_insn(r_type(`RV_F7_ALT, 5'd2, 5'd1, `RV_F3_SRL_SRA, 5'd20), 1'b1, 5'd20,
			$signed(x1) >>> x2[4:0]);
		expect_insn(i_type(12'd5, 5'd1, `RV_F3_SLL, 5'd11, `RV_OP_IMM), 1'b1, 5'd11, x1 << 5);
		expect_insn(i_type(12'd3, 5'd1, `RV_F3_SRL_SRA, 5'd12, `RV_OP_IMM), 1'b1, 5'd12, x1 >> 3);
		expect_insn(i_type({`RV_F7_ALT, 5'd3}, 5'd1, `RV_F3_SRL_SRA, 5'd13, `RV_OP_IMM), 1'b1,
			5'd13, $signed(x1) >>> 3);
		expect_insn(u_type(20'habcde, 5'd14, `RV_OP_LUI), 1'b1, 5'd14, 32'habcd_e000);
		expect_insn(u_type(20'h00012, 5'd15, `RV_OP_AUIPC), 1'b1, 5'd15, next_pc + 32'h0001_2000);
		// x0 write still pulses, then reads back as zero
		expect_insn(i_type(12'd7, 5'd1, `RV_F3_ADD_SUB, 5'd0, `RV_OP_IMM), 1'b1, 5'd0, x1 + 32'd7);
		expect_insn(r_type(`RV_F7_BASE, 5'd0, 5'd0, `RV_F3_ADD_SUB, 5'd5), 1'b1, 5'd5, 32'd0);
		// beq x5,x0 taken over one word
		expect_insn(b_type(13'd8, 5'd0, 5'd5, `RV_F3_BEQ), 1'b0, 5'd0, 32'd0);
		pad_insn(i_type(12'd1, 5'd0, `RV_F3_ADD_SUB, 5'd16, `RV_OP_IMM));
		// bne x5,x0 falls through
		expect_insn(b_type(13'd8, 5'd0, 5'd5, `RV_F3_BNE), 1'b0, 5'd0, 32'd0);
		expect_insn(j_type(21'd8, 5'd17), 1'b1, 5'd17, next_pc + 32'd4);
		pad_insn(i_type(12'd2, 5'd0, `RV_F3_ADD_SUB, 5'd16, `RV_OP_IMM));
		// jalr lands past two pad words, odd offset has bit 0 cleared
		land = next_pc + 32'd16;
		expect_insn(i_type(land[11:0], 5'd0, `RV_F3_ADD_SUB, 5'd18, `RV_OP_IMM), 1'b1, 5'd18, land);
		expect_insn(i_type(12'd1, 5'd18, `RV_F3_JALR, 5'd19, `RV_OP_JALR), 1'b1, 5'd19,
			next_pc + 32'd4);
		pad_insn(i_type(12'd3, 5'd0, `RV_F3_ADD_SUB, 5'd16, `RV_OP_IMM));
		pad_insn(i_type(12'd4, 5'd0, `RV_F3_ADD_SUB, 5'd16, `RV_OP_IMM));
		stop_insn(`RV_EBREAK);
		expect_invalid = 1'b0;
		test_name      = "program_a";
	endtask

	task automatic assemble_illegal;
		clear_image();
		expect_insn(i_type(12'd5, 5'd0, `RV_F3_ADD_SUB, 5'd1, `RV_OP_IMM), 1'b1, 5'd1, 32'd5);
		expect_insn(i_type(12'd3, 5'd1, `RV_F3_ADD_SUB, 5'd2, `RV_OP_IMM), 1'b1, 5'd2, 32'd8);
		// lw x3,0(x1), no loads in this core
		stop_insn(i_type(12'd0, 5'd1, 3'b010, 5'd3, 7'b0000011));
		expect_invalid = 1'b1;
		test_name      = "program_b";
	endtask

	// a few cycles past the stop to watch it stay quiet
	task automatic run_until_stop;
		while (!(halt || invalid)) begin
			@(negedge clk);
		end
		repeat (8) @(negedge clk);
	endtask

	a_reset_state: assert property (@(posedge clk) disable iff (!rst)
		$rose(rst) |-> (pc == `RV_RESET_PC && instret == 0 && !wb_en && !halt && !invalid))
		else begin
			errors++;
			$display("[FAIL] %s reset: expected pc=%h instret=0 flags=000, actual pc=%h instret=%0d flags=%b%b%b",
				test_name, `RV_RESET_PC, $sampled(pc), $sampled(instret), $sampled(wb_en),
				$sampled(halt), $sampled(invalid));
		end

	a_wb_value: assert property (@(posedge clk) disable iff (!rst)
		wb_en |-> (exp_wen[instret[4:0]] && wb_reg == exp_rd[instret[4:0]] &&
			wb_data == exp_val[instret[4:0]]))
		else begin
			errors++;
			$display("[FAIL] %s write #%0d: expected wen=%b x%0d=%h, actual x%0d=%h", test_name,
				$sampled(instret), exp_wen[$sampled(instret[4:0])], exp_rd[$sampled(instret[4:0])],
				exp_val[$sampled(instret[4:0])], $sampled(wb_reg), $sampled(wb_data));
		end

	// a retired instruction that should have written but did not
	a_wb_missing: assert property (@(posedge clk) disable iff (!rst)
		($changed(instret) && instret != 0) |-> ($past(wb_en) == exp_wen[$past(instret[4:0])]))
		else begin
			errors++;
			$display("[FAIL] %s retire #%0d: expected wen=%b, actual wen=%b", test_name,
				$past(instret), exp_wen[$past(instret[4:0])], $past(wb_en));
		end

	a_instret_step: assert property (@(posedge clk) disable iff (!rst)
		($changed(instret) && instret != 0) |-> (instret == $past(instret) + 1))
		else begin
			errors++;
			$display("[FAIL] %s instret: expected %0d, actual %0d", test_name,
				$past(instret) + 1, $sampled(instret));
		end

	// back to back writers pulse every third cycle
	a_wb_spacing: assert property (@(posedge clk) disable iff (!rst)
		(wb_en && instret != 0 && exp_wen[instret[4:0] - 5'd1]) |->
			($past(wb_en, 3) && !$past(wb_en, 1) && !$past(wb_en, 2)))
		else begin
			errors++;
			$display("write-back pulses in %s at write #%0d are not 3 cycles apart",
				test_name, $sampled(instret));
		end

	a_pc_seq: assert property (@(posedge clk) disable iff (!rst)
		pc == exp_pc[instret[4:0]] && imem_addr == pc)
		else begin
			errors++;
			$display("[FAIL] %s pc at instret %0d: expected %h, actual pc=%h addr=%h", test_name,
				$sampled(instret), exp_pc[$sampled(instret[4:0])], $sampled(pc),
				$sampled(imem_addr));
		end

	a_stop_quiet: assert property (@(posedge clk) disable iff (!rst)
		(halt || invalid) |-> (!wb_en && $stable(pc) && instret == exp_count))
		else begin
			errors++;
			$display("[FAIL] %s stopped core: expected instret=%0d no write, actual instret=%0d wb_en=%b",
				test_name, exp_count, $sampled(instret), $sampled(wb_en));
		end

	a_stop_cause: assert property (@(posedge clk) disable iff (!rst)
		(halt || invalid) |-> (invalid == expect_invalid && halt != expect_invalid))
		else begin
			errors++;
			$display("[FAIL] %s stop cause: expected invalid=%b, actual halt=%b invalid=%b",
				test_name, expect_invalid, $sampled(halt), $sampled(invalid));
		end

	always @(negedge clk) begin
		if (wb_en) begin
			writes_seen++;
		end
	end

	always @(posedge clk) begin
		cycles = cycles + 1;
		if (cycles > CYCLE_LIMIT) begin
			$display("timeout, the core did not stop within %0d cycles", CYCLE_LIMIT);
			$display("Test failed");
			$finish;
		end
	end

	initial begin
		seed = 32'h2c4d_7700;
		rst  = 1'b0;
		assemble_main();
		repeat (2) @(negedge clk);
		rst = 1'b1;
		run_until_stop();
		// second run from a fresh reset
		rst = 1'b0;
		assemble_illegal();
		repeat (2) @(negedge clk);
		rst = 1'b1;
		run_until_stop();
		$display("writes seen %0d, errors %0d", writes_seen, errors);
		if (errors == 0) begin
			$display("Test passed");
		end else begin
			$display("Test failed");
		end
		$finish;
	end

endmodule

// File: hw/rv_core_top.sv
`timescale 1ns/1ps
`include "rv_consts.svh"

module rv_core_top (
	input  logic                clk,
	input  logic                rst,
	input  logic [`RV_XLEN-1:0] imem_data_i,
	output logic [`RV_XLEN-1:0] imem_addr_o,
	output logic [`RV_XLEN-1:0] pc_o,
	output logic                wb_en_o,
	output logic [4:0]          wb_reg_o,
	output logic [`RV_XLEN-1:0] wb_data_o,
	output logic [`RV_XLEN-1:0] instret_o,
	output logic                halt_o,
	output logic                invalid_o
);

	// fsm strobes
	logic ir_load;
	logic res_load;
	logic commit;

	// decoder outputs
	logic [4:0]          rs1;
	logic [4:0]          rs2;
	logic [4:0]          rd;
	logic                rd_wen;
	logic [`RV_XLEN-1:0] imm;
	rv_pkg::alu_op_e     alu_op;
	logic                use_imm;
	logic                use_pc;
	rv_pkg::pc_kind_e    pc_kind;
	logic                branch_ne;
	logic                illegal;
	logic                is_ebreak;

	// datapath
	logic [`RV_XLEN-1:0] pc;
	logic [`RV_XLEN-1:0] rs1_data;
	logic [`RV_XLEN-1:0] rs2_data;
	logic [`RV_XLEN-1:0] result;
	logic                take_branch;
	logic [`RV_XLEN-1:0] jalr_target;

	assign imem_addr_o = pc;
	assign pc_o        = pc;
	// write-back port mirrors the regfile write
	assign wb_en_o     = commit & rd_wen;
	assign wb_reg_o    = rd;
	assign wb_data_o   = result;

	rv_ctrl_fsm u_ctrl_fsm (
		.clk        (clk),
		.rst        (rst),
		.illegal_i  (illegal),
		.ebreak_i   (is_ebreak),
		.ir_load_o  (ir_load),
		.res_load_o (res_load),
		.commit_o   (commit),
		.halt_o     (halt_o),
		.invalid_o  (invalid_o)
	);

	rv_pc_counter u_pc_counter (
		.clk           (clk),
		.rst           (rst),
		.commit_i      (commit),
		.pc_kind_i     (pc_kind),
		.imm_i         (imm),
		.take_branch_i (take_branch),
		.jalr_target_i (jalr_target),
		.pc_o          (pc),
		.instret_o     (instret_o)
	);

	rv_regfile u_regfile (
		.clk      (clk),
		.rst      (rst),
		.we_i     (wb_en_o),
		.waddr_i  (rd),
		.wdata_i  (result),
		.raddr1_i (rs1),
		.raddr2_i (rs2),
		.rdata1_o (rs1_data),
		.rdata2_o (rs2_data)
	);

	rv_decoder u_decoder (
		.clk         (clk),
		.rst         (rst),
		.ir_load_i   (ir_load),
		.imem_data_i (imem_data_i),
		.rs1_o       (rs1),
		.rs2_o       (rs2),
		.rd_o        (rd),
		.rd_wen_o    (rd_wen),
		.imm_o       (imm),
		.alu_op_o    (alu_op),
		.use_imm_o   (use_imm),
		.use_pc_o    (use_pc),
		.pc_kind_o   (pc_kind),
		.branch_ne_o (branch_ne),
		.illegal_o   (illegal),
		.ebreak_o    (is_ebreak)
	);

	rv_alu u_alu (
		.clk           (clk),
		.rst           (rst),
		.res_load_i    (res_load),
		.alu_op_i      (alu_op),
		.rs1_data_i    (rs1_data),
		.rs2_data_i    (rs2_data),
		.imm_i         (imm),
		.pc_i          (pc),
		.use_imm_i     (use_imm),
		.use_pc_i      (use_pc),
		.branch_ne_i   (branch_ne),
		.result_o      (result),
		.take_branch_o (take_branch),
		.jalr_target_o (jalr_target)
	);

endmodule

// File: hw/rv_alu.sv
`timescale 1ns/1ps
`include "rv_consts.svh"

module rv_alu (
	input  logic                clk,
	input  logic                rst,
	input  logic                res_load_i,
	input  rv_pkg::alu_op_e     alu_op_i,
	input  logic [`RV_XLEN-1:0] rs1_data_i,
	input  logic [`RV_XLEN-1:0] rs2_data_i,
	input  logic [`RV_XLEN-1:0] imm_i,
	input  logic [`RV_XLEN-1:0] pc_i,
	input  logic                use_imm_i,
	input  logic                use_pc_i,
	input  logic                branch_ne_i,
	output logic [`RV_XLEN-1:0] result_o,
	output logic                take_branch_o,
	output logic [`RV_XLEN-1:0] jalr_target_o
);

	logic [`RV_XLEN-1:0] op_a;
	logic [`RV_XLEN-1:0] op_b;
	logic [4:0]          shamt;
	logic [`RV_XLEN-1:0] alu_out;
	logic [`RV_XLEN-1:0] jalr_sum;

	// operand muxing, auipc takes pc, imm forms take imm
	assign op_a  = use_pc_i ? pc_i : rs1_data_i;
	assign op_b  = use_imm_i ? imm_i : rs2_data_i;
	assign shamt = op_b[4:0];

	always_comb begin
		case (alu_op_i)
			rv_pkg::ADD:    alu_out = op_a + op_b;
			rv_pkg::SUB:    alu_out = op_a - op_b;
			rv_pkg::SLL:    alu_out = op_a << shamt;
			rv_pkg::SLT:    alu_out = {{(`RV_XLEN-1){1'b0}}, $signed(op_a) < $signed(op_b)};
			rv_pkg::SLTU:   alu_out = {{(`RV_XLEN-1){1'b0}}, op_a < op_b};
			rv_pkg::XOR:    alu_out = op_a ^ op_b;
			rv_pkg::SRL:    alu_out = op_a >> shamt;
			rv_pkg::SRA:    alu_out = $unsigned($signed(op_a) >>> shamt);
			rv_pkg::OR:     alu_out = op_a | op_b;
			rv_pkg::AND:    alu_out = op_a & op_b;
			rv_pkg::PASS_B: alu_out = op_b;
			// link address for jal / jalr
			rv_pkg::LINK:   alu_out = pc_i + 4;
			default:        alu_out = '0;
		endcase
	end

	// result held through wb
	always_ff @(posedge clk) begin
		if (!rst) begin
			result_o <= '0;
		end else if (res_load_i) begin
			result_o <= alu_out;
		end
	end

	// beq / bne on raw register values
	assign take_branch_o = (rs1_data_i == rs2_data_i) ^ branch_ne_i;

	// jalr target, low bit dropped
	assign jalr_sum      = rs1_data_i + imm_i;
	assign jalr_target_o = {jalr_sum[`RV_XLEN-1:1], 1'b0};

endmodule

// File: hw/rv_decoder.sv
`timescale 1ns/1ps
`include "rv_consts.svh"

module rv_decoder (
	input  logic                clk,
	input  logic                rst,
	input  logic                ir_load_i,
	input  logic [`RV_XLEN-1:0] imem_data_i,
	output logic [4:0]          rs1_o,
	output logic [4:0]          rs2_o,
	output logic [4:0]          rd_o,
	output logic                rd_wen_o,
	output logic [`RV_XLEN-1:0] imm_o,
	output rv_pkg::alu_op_e     alu_op_o,
	output logic                use_imm_o,
	output logic                use_pc_o,
	output rv_pkg::pc_kind_e    pc_kind_o,
	output logic                branch_ne_o,
	output logic                illegal_o,
	output logic                ebreak_o
);

	logic [`RV_XLEN-1:0] ir;
	logic [6:0]          opcode;
	logic [2:0]          funct3;
	logic [6:0]          funct7;
	logic [`RV_XLEN-1:0] imm_i_type;
	logic [`RV_XLEN-1:0] imm_u_type;
	logic [`RV_XLEN-1:0] imm_j_type;
	logic [`RV_XLEN-1:0] imm_b_type;
	rv_pkg::alu_op_e     f3_op;
	logic                legal;

	// instruction register, loaded in fetch
	always_ff @(posedge clk) begin
		if (!rst) begin
			ir <= '0;
		end else if (ir_load_i) begin
			ir <= imem_data_i;
		end
	end

	assign opcode = ir[6:0];
	assign funct3 = ir[14:12];
	assign funct7 = ir[31:25];

	assign rs1_o = ir[19:15];
	assign rs2_o = ir[24:20];
	assign rd_o  = ir[11:7];

	// sign-extended immediates
	assign imm_i_type = {{20{ir[31]}}, ir[31:20]};
	assign imm_u_type = {ir[31:12], 12'b0};
	assign imm_j_type = {{12{ir[31]}}, ir[19:12], ir[20], ir[30:21], 1'b0};
	assign imm_b_type = {{20{ir[31]}}, ir[7], ir[30:25], ir[11:8], 1'b0};

	// funct3 -> op, shared by OP and OP-IMM
	always_comb begin
		case (funct3)
			// sub only exists for register form
			`RV_F3_ADD_SUB: f3_op = (opcode == `RV_OP_REG && funct7 == `RV_F7_ALT) ?
				rv_pkg::SUB : rv_pkg::ADD;
			`RV_F3_SLL:     f3_op = rv_pkg::SLL;
			`RV_F3_SLT:     f3_op = rv_pkg::SLT;
			`RV_F3_SLTU:    f3_op = rv_pkg::SLTU;
			`RV_F3_XOR:     f3_op = rv_pkg::XOR;
			`RV_F3_SRL_SRA: f3_op = (funct7 == `RV_F7_ALT) ? rv_pkg::SRA : rv_pkg::SRL;
			`RV_F3_OR:      f3_op = rv_pkg::OR;
			default:        f3_op = rv_pkg::AND;
		endcase
	end

	always_comb begin
		rd_wen_o  = 1'b0;
		imm_o     = imm_i_type;
		alu_op_o  = rv_pkg::ADD;
		use_imm_o = 1'b0;
		use_pc_o  = 1'b0;
		pc_kind_o = rv_pkg::PC_SEQ;
		case (opcode)
			`RV_OP_LUI: begin
				rd_wen_o  = 1'b1;
				imm_o     = imm_u_type;
				alu_op_o  = rv_pkg::PASS_B;
				use_imm_o = 1'b1;
			end
			`RV_OP_AUIPC: begin
				rd_wen_o  = 1'b1;
				imm_o     = imm_u_type;
				use_imm_o = 1'b1;
				use_pc_o  = 1'b1;
			end
			`RV_OP_JAL: begin
				rd_wen_o  = 1'b1;
				imm_o     = imm_j_type;
				alu_op_o  = rv_pkg::LINK;
				pc_kind_o = rv_pkg::PC_JAL;
			end
			`RV_OP_JALR: begin
				rd_wen_o  = 1'b1;
				alu_op_o  = rv_pkg::LINK;
				pc_kind_o = rv_pkg::PC_JALR;
			end
			`RV_OP_BRANCH: begin
				imm_o     = imm_b_type;
				pc_kind_o = rv_pkg::PC_BRANCH;
			end
			`RV_OP_IMM: begin
				rd_wen_o  = 1'b1;
				alu_op_o  = f3_op;
				use_imm_o = 1'b1;
			end
			`RV_OP_REG: begin
				rd_wen_o = 1'b1;
				alu_op_o = f3_op;
			end
			`RV_OP_SYSTEM: begin
				// ebreak, no write
				rd_wen_o = 1'b0;
			end
			default: begin
				rd_wen_o = 1'b0;
			end
		endcase
	end

	// beq vs bne
	assign branch_ne_o = (funct3 == `RV_F3_BNE);

	// kept subset only
	assign legal =
		(opcode == `RV_OP_LUI) |
		(opcode == `RV_OP_AUIPC) |
		(opcode == `RV_OP_JAL) |
		(opcode == `RV_OP_JALR && funct3 == `RV_F3_JALR) |
		(opcode == `RV_OP_BRANCH && (funct3 == `RV_F3_BEQ || funct3 == `RV_F3_BNE)) |
		(opcode == `RV_OP_IMM && funct3 != `RV_F3_SLL && funct3 != `RV_F3_SRL_SRA) |
		// slli srli srai
		(opcode == `RV_OP_IMM && funct3 == `RV_F3_SLL && funct7 == `RV_F7_BASE) |
		(opcode == `RV_OP_IMM && funct3 == `RV_F3_SRL_SRA &&
			(funct7 == `RV_F7_BASE || funct7 == `RV_F7_ALT)) |
		// R type, alt funct7 only for sub and sra
		(opcode == `RV_OP_REG && funct7 == `RV_F7_BASE) |
		(opcode == `RV_OP_REG && funct7 == `RV_F7_ALT &&
			(funct3 == `RV_F3_ADD_SUB || funct3 == `RV_F3_SRL_SRA)) |
		(ir == `RV_EBREAK);

	assign illegal_o = ~legal;
	assign ebreak_o  = (ir == `RV_EBREAK);

endmodule

// File: hw/rv_regfile.sv
`timescale 1ns/1ps
`include "rv_consts.svh"

module rv_regfile (
	input  logic                clk,
	input  logic                rst,
	input  logic                we_i,
	input  logic [4:0]          waddr_i,
	input  logic [`RV_XLEN-1:0] wdata_i,
	input  logic [4:0]          raddr1_i,
	input  logic [4:0]          raddr2_i,
	output logic [`RV_XLEN-1:0] rdata1_o,
	output logic [`RV_XLEN-1:0] rdata2_o
);

	logic [`RV_XLEN-1:0] regs [32];

	// writes to x0 are dropped here
	always_ff @(posedge clk) begin
		if (!rst) begin
			for (int i = 0; i < 32; i++) begin
				regs[i] <= '0;
			end
		end else if (we_i && waddr_i != 5'd0) begin
			regs[waddr_i] <= wdata_i;
		end
	end

	// async read, x0 keeps its reset zero
	assign rdata1_o = regs[raddr1_i];
	assign rdata2_o = regs[raddr2_i];

	a_x0_zero: assert property (@(posedge clk) disable iff (!rst)
		((raddr1_i == 5'd0) |-> (rdata1_o == '0)) and
		((raddr2_i == 5'd0) |-> (rdata2_o == '0)))
		else $error("regfile: x0 read nonzero");

endmodule

// File: hw/rv_pc_counter.sv
`timescale 1ns/1ps
`include "rv_consts.svh"

module rv_pc_counter (
	input  logic                clk,
	input  logic                rst,
	input  logic                commit_i,
	input  rv_pkg::pc_kind_e    pc_kind_i,
	input  logic [`RV_XLEN-1:0] imm_i,
	input  logic                take_branch_i,
	input  logic [`RV_XLEN-1:0] jalr_target_i,
	output logic [`RV_XLEN-1:0] pc_o,
	output logic [`RV_XLEN-1:0] instret_o
);

	logic [`RV_XLEN-1:0] pc_plus4;
	logic [`RV_XLEN-1:0] pc_rel;
	logic [`RV_XLEN-1:0] pc_next;

	assign pc_plus4 = pc_o + 4;
	// branch and jal offsets are pc relative
	assign pc_rel   = pc_o + imm_i;

	always_comb begin
		case (pc_kind_i)
			rv_pkg::PC_BRANCH: pc_next = take_branch_i ? pc_rel : pc_plus4;
			rv_pkg::PC_JAL:    pc_next = pc_rel;
			// target already formed in the execute unit
			rv_pkg::PC_JALR:   pc_next = jalr_target_i;
			default:           pc_next = pc_plus4;
		endcase
	end

	// pc and instret move together at the end of wb
	always_ff @(posedge clk) begin
		if (!rst) begin
			pc_o      <= `RV_RESET_PC;
			instret_o <= '0;
		end else if (commit_i) begin
			pc_o      <= pc_next;
			instret_o <= instret_o + 1;
		end
	end

	a_pc_aligned: assert property (@(posedge clk) disable iff (!rst)
		pc_o[1:0] == 2'b00)
		else $error("pc counter: misaligned pc %h", pc_o);

endmodule

// File: hw/rv_ctrl_fsm.sv
`timescale 1ns/1ps

module rv_ctrl_fsm (
	input  logic clk,
	input  logic rst,
	input  logic illegal_i,
	input  logic ebreak_i,
	output logic ir_load_o,
	output logic res_load_o,
	output logic commit_o,
	output logic halt_o,
	output logic invalid_o
);

	rv_pkg::ctrl_state_e state;
	logic                halt_q;
	logic                invalid_q;

	// fetch -> exec -> wb, one cycle each
	always_ff @(posedge clk) begin
		if (!rst) begin
			state     <= rv_pkg::ST_FETCH;
			halt_q    <= 1'b0;
			invalid_q <= 1'b0;
		end else begin
			case (state)
				rv_pkg::ST_FETCH: begin
					state <= rv_pkg::ST_EXEC;
				end
				rv_pkg::ST_EXEC: begin
					// decode is valid here, ir loaded on the fetch edge
					if (illegal_i) begin
						state     <= rv_pkg::ST_HALT;
						invalid_q <= 1'b1;
					end else if (ebreak_i) begin
						state  <= rv_pkg::ST_HALT;
						halt_q <= 1'b1;
					end else begin
						state <= rv_pkg::ST_WB;
					end
				end
				rv_pkg::ST_WB: begin
					state <= rv_pkg::ST_FETCH;
				end
				default: begin
					// halt, wait for reset
					state <= rv_pkg::ST_HALT;
				end
			endcase
		end
	end

	// strobes straight from state
	assign ir_load_o  = (state == rv_pkg::ST_FETCH);
	assign res_load_o = (state == rv_pkg::ST_EXEC);
	assign commit_o   = (state == rv_pkg::ST_WB);

	assign halt_o    = halt_q;
	assign invalid_o = invalid_q;

	// one strobe per cycle until a stop cause is latched, none after
	a_one_strobe: assert property (@(posedge clk) disable iff (!rst)
		$onehot({ir_load_o, res_load_o, commit_o}) == !(halt_o || invalid_o))
		else $error("ctrl fsm: strobes disagree with stop cause");

	// a stop has one cause only
	a_one_cause: assert property (@(posedge clk) disable iff (!rst)
		!(halt_o && invalid_o))
		else $error("ctrl fsm: halt and invalid both set");

endmodule

// File: hw/rv_pkg.sv
package rv_pkg;

	// control FSM states
	typedef enum logic [1:0] {
		ST_FETCH = 2'd0,
		ST_EXEC  = 2'd1,
		ST_WB    = 2'd2,
		ST_HALT  = 2'd3
	} ctrl_state_e;

	// execute unit operations
	typedef enum logic [3:0] {
		ADD    = 4'd0,
		SUB    = 4'd1,
		SLL    = 4'd2,
		SLT    = 4'd3,
		SLTU   = 4'd4,
		XOR    = 4'd5,
		SRL    = 4'd6,
		SRA    = 4'd7,
		OR     = 4'd8,
		AND    = 4'd9,
		// lui, operand b straight through
		PASS_B = 4'd10,
		// jal / jalr, result is pc+4
		LINK   = 4'd11
	} alu_op_e;

	// next pc source
	typedef enum logic [1:0] {
		PC_SEQ    = 2'd0,
		PC_BRANCH = 2'd1,
		PC_JAL    = 2'd2,
		PC_JALR   = 2'd3
	} pc_kind_e;

endpackage

// File: hw/rv_consts.svh
`ifndef RV_CONSTS_SVH
`define RV_CONSTS_SVH

// datapath and address width
`define RV_XLEN 32

// first fetch after reset
`define RV_RESET_PC 32'h0000_0000

// major opcodes, inst[6:0]
`define RV_OP_LUI    7'b0110111
`define RV_OP_AUIPC  7'b0010111
`define RV_OP_JAL    7'b1101111
`define RV_OP_JALR   7'b1100111
`define RV_OP_BRANCH 7'b1100011
`define RV_OP_IMM    7'b0010011
`define RV_OP_REG    7'b0110011
`define RV_OP_SYSTEM 7'b1110011

// funct3 for OP / OP-IMM
`define RV_F3_ADD_SUB 3'b000
`define RV_F3_SLL     3'b001
`define RV_F3_SLT     3'b010
`define RV_F3_SLTU    3'b011
`define RV_F3_XOR     3'b100
`define RV_F3_SRL_SRA 3'b101
`define RV_F3_OR      3'b110
`define RV_F3_AND     3'b111

// funct3 for branches and jalr
`define RV_F3_BEQ  3'b000
`define RV_F3_BNE  3'b001
`define RV_F3_JALR 3'b000

// funct7, base and alternate (sub, sra, srai)
`define RV_F7_BASE 7'b0000000
`define RV_F7_ALT  7'b0100000

// ebreak, whole word
`define RV_EBREAK 32'h0010_0073

`endif
